/* upsample2x_pkg.sv */
package upsample2x_pkg;

    // datapath widths
    localparam int SAMPLE_W = 24;
    localparam int COEFF_W = 16;

    // polyphase geometry, fixed by the coefficient table
    localparam int FIRDEPTH = 32;
    localparam int NUM_FIR = 2;

    localparam int TAP_W = $clog2(FIRDEPTH);
    localparam int PHASE_W = $clog2(NUM_FIR);
    localparam int BANK_W = PHASE_W + TAP_W;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RESULT,
        ST_CALC,
        ST_DRAIN,
        ST_NEXT_FIR
    } fir_state_e;

    // 64-tap hann-windowed half-band lowpass, even taps in phase 0, odd taps in phase 1
    // each phase sums to roughly unity in Q1.15
    localparam logic signed [COEFF_W-1:0] COEFF_TABLE [NUM_FIR][FIRDEPTH] = '{
        '{
            16'sd0, 16'sd8, -16'sd26, 16'sd57, -16'sd103, 16'sd166, -16'sd251, 16'sd360,
            -16'sd498, 16'sd678, -16'sd915, 16'sd1240, -16'sd1711, 16'sd2490,
            -16'sd4092, 16'sd9785, 16'sd29472, -16'sd5813, 16'sd3120, -16'sd2048,
            16'sd1452, -16'sd1064, 16'sd788, -16'sd582, 16'sd425, -16'sd301,
            16'sd206, -16'sd132, 16'sd78, -16'sd40, 16'sd15, -16'sd3
        },
        '{
            -16'sd3, 16'sd15, -16'sd40, 16'sd78, -16'sd132, 16'sd206, -16'sd301, 16'sd425,
            -16'sd582, 16'sd788, -16'sd1064, 16'sd1452, -16'sd2048, 16'sd3120,
            -16'sd5813, 16'sd29472, 16'sd9785, -16'sd4092, 16'sd2490, -16'sd1711,
            16'sd1240, -16'sd915, 16'sd678, -16'sd498, 16'sd360, -16'sd251,
            16'sd166, -16'sd103, 16'sd57, -16'sd26, 16'sd8, 16'sd0
        }
    };

endpackage

/* coeff_rom.sv */
`timescale 1ns/1ns

module coeff_rom (
    input  logic [upsample2x_pkg::BANK_W-1:0]         bank_addr_i,
    output logic signed [upsample2x_pkg::COEFF_W-1:0] coeff_o
);

    logic [upsample2x_pkg::PHASE_W-1:0] phase;
    logic [upsample2x_pkg::TAP_W-1:0]   tap;

    // address is {phase, tap}
    assign phase = bank_addr_i[upsample2x_pkg::BANK_W-1:upsample2x_pkg::TAP_W];
    assign tap = bank_addr_i[upsample2x_pkg::TAP_W-1:0];

    always_comb begin
        // unused phase codes read as zero
        if (int'(phase) < upsample2x_pkg::NUM_FIR) begin
            coeff_o = upsample2x_pkg::COEFF_TABLE[phase][tap];
        end else begin
            coeff_o = '0;
        end
    end

endmodule

/* sample_ring.sv */
`timescale 1ns/1ns

module sample_ring #(
    parameter int RING_LEN = 64
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [upsample2x_pkg::SAMPLE_W-1:0] data_i,
    input  logic                                we_i,
    input  logic                                pop_i,
    input  logic [upsample2x_pkg::TAP_W-1:0]    offset_i,
    output logic [upsample2x_pkg::SAMPLE_W-1:0] data_o
);

    localparam int PTR_W = $clog2(RING_LEN);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(RING_LEN - 1);
    localparam logic [PTR_W:0] SUM_WRAP = (PTR_W + 1)'(RING_LEN);

    logic [upsample2x_pkg::SAMPLE_W-1:0] mem [RING_LEN];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   rd_sum;
    logic [PTR_W-1:0] rd_addr;

    // no back-pressure, a full ring overwrites the oldest entry
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (we_i) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
        end
    end

    // retire the oldest sample
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (pop_i) begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
        end
    end

    // read pointer plus tap offset, modulo ring length
    always_comb begin
        rd_sum = {1'b0, rd_ptr} + (PTR_W + 1)'(offset_i);
        if (rd_sum >= SUM_WRAP) begin
            rd_addr = PTR_W'(rd_sum - SUM_WRAP);
        end else begin
            rd_addr = rd_sum[PTR_W-1:0];
        end
    end

    assign data_o = mem[rd_addr];

endmodule

/* poly_fir.sv */
`timescale 1ns/1ns

module poly_fir (
    input  logic                                       clk,
    input  logic                                       rst,
    output logic [upsample2x_pkg::BANK_W-1:0]          bank_addr_o,
    input  logic signed [upsample2x_pkg::COEFF_W-1:0]  coeff_i,
    output logic                                       ring_pop_o,
    output logic [upsample2x_pkg::TAP_W-1:0]           offset_o,
    input  logic signed [upsample2x_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                                       req_i,
    output logic [upsample2x_pkg::SAMPLE_W-1:0]        data_o,
    output logic                                       ack_o
);

    localparam int CNT_W = upsample2x_pkg::TAP_W + 1;
    localparam int PHASE_W = upsample2x_pkg::PHASE_W;
    localparam int PROD_W = upsample2x_pkg::SAMPLE_W + upsample2x_pkg::COEFF_W;

    // products are scaled down by 2^16 before accumulation
    localparam int PROD_SHIFT = 16;

    // loads run for taps 0..FIRDEPTH-1, calc ends two cycles later
    localparam logic [CNT_W-1:0] TAP_END = CNT_W'(upsample2x_pkg::FIRDEPTH);
    localparam logic [CNT_W-1:0] CALC_LAST = CNT_W'(upsample2x_pkg::FIRDEPTH + 1);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(upsample2x_pkg::NUM_FIR - 1);

    upsample2x_pkg::fir_state_e state_q;

    logic [CNT_W-1:0]   tap_cnt;
    logic [PHASE_W-1:0] phase_q;
    logic [PHASE_W-1:0] pop_cnt;

    logic                                       load_en;
    logic                                       p1_vld;
    logic                                       p2_vld;
    logic signed [upsample2x_pkg::SAMPLE_W-1:0] sample_q;
    logic signed [upsample2x_pkg::COEFF_W-1:0]  coeff_q;
    logic signed [PROD_W-1:0]                   full_prod;
    logic signed [upsample2x_pkg::SAMPLE_W-1:0] prod_q;
    logic signed [upsample2x_pkg::SAMPLE_W-1:0] acc_q;
    logic [upsample2x_pkg::SAMPLE_W-1:0]        out_q;

    assign offset_o = tap_cnt[upsample2x_pkg::TAP_W-1:0];
    assign bank_addr_o = {phase_q, tap_cnt[upsample2x_pkg::TAP_W-1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= upsample2x_pkg::ST_IDLE;
            tap_cnt <= '0;
            phase_q <= '0;
            pop_cnt <= '0;
        end else begin
            unique case (state_q)
                upsample2x_pkg::ST_IDLE: begin
                    // requests are only taken here, busy requests are dropped
                    if (req_i) begin
                        state_q <= upsample2x_pkg::ST_RESULT;
                    end
                end
                upsample2x_pkg::ST_RESULT: begin
                    tap_cnt <= '0;
                    state_q <= upsample2x_pkg::ST_CALC;
                end
                upsample2x_pkg::ST_CALC: begin
                    if (tap_cnt == CALC_LAST) begin
                        state_q <= upsample2x_pkg::ST_DRAIN;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                upsample2x_pkg::ST_DRAIN: begin
                    state_q <= upsample2x_pkg::ST_NEXT_FIR;
                end
                upsample2x_pkg::ST_NEXT_FIR: begin
                    phase_q <= (phase_q == PHASE_LAST) ? '0 : phase_q + 1'b1;
                    pop_cnt <= (pop_cnt == PHASE_LAST) ? '0 : pop_cnt + 1'b1;
                    state_q <= upsample2x_pkg::ST_IDLE;
                end
                default: begin
                    state_q <= upsample2x_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // one retired sample per NUM_FIR outputs
    assign ring_pop_o = (state_q == upsample2x_pkg::ST_NEXT_FIR) && (pop_cnt == PHASE_LAST);

    assign load_en = (state_q == upsample2x_pkg::ST_CALC) && (tap_cnt < TAP_END);

    // stage 1, sample and coefficient pair
    always_ff @(posedge clk) begin
        if (load_en) begin
            sample_q <= sample_i;
            coeff_q <= coeff_i;
        end
    end

    assign full_prod = sample_q * coeff_q;

    // stage 2, arithmetic shift then keep the low 24 bits
    always_ff @(posedge clk) begin
        prod_q <= full_prod[PROD_SHIFT +: upsample2x_pkg::SAMPLE_W];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            p1_vld <= 1'b0;
            p2_vld <= 1'b0;
        end else begin
            p1_vld <= load_en;
            p2_vld <= p1_vld;
        end
    end

    // stage 3, accumulate exactly FIRDEPTH products
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= '0;
            out_q <= '0;
        end else begin
            // output updates only on the ack edge, so it holds between acks
            if (state_q == upsample2x_pkg::ST_IDLE && req_i) begin
                out_q <= acc_q;
            end
            if (state_q == upsample2x_pkg::ST_RESULT) begin
                acc_q <= '0;
            end else if (p2_vld) begin
                acc_q <= acc_q + prod_q;
            end
        end
    end

    assign ack_o = (state_q == upsample2x_pkg::ST_RESULT);
    assign data_o = out_q;

endmodule

/* upsample2x.sv */
`timescale 1ns/1ns

module upsample2x #(
    parameter int RING_LEN = 64
) (
    input  logic                                clk,
    input  logic                                rst,

    // upstream source
    input  logic [upsample2x_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                                in_ack_i,
    output logic                                in_pop_o,

    // downstream consumer
    input  logic                                out_pop_i,
    output logic [upsample2x_pkg::SAMPLE_W-1:0] out_data_o,
    output logic                                out_ack_o
);

    logic [upsample2x_pkg::BANK_W-1:0]         bank_addr;
    logic signed [upsample2x_pkg::COEFF_W-1:0] coeff;
    logic [upsample2x_pkg::TAP_W-1:0]          offset;
    logic [upsample2x_pkg::SAMPLE_W-1:0]       ring_data;

    // in_pop_o doubles as the ring's read-pointer advance
    sample_ring #(
        .RING_LEN(RING_LEN)
    ) sample_ring_inst (
        .clk      (clk),
        .rst      (rst),
        .data_i   (in_data_i),
        .we_i     (in_ack_i),
        .pop_i    (in_pop_o),
        .offset_i (offset),
        .data_o   (ring_data)
    );

    coeff_rom coeff_rom_inst (
        .bank_addr_i (bank_addr),
        .coeff_o     (coeff)
    );

    poly_fir poly_fir_inst (
        .clk         (clk),
        .rst         (rst),
        .bank_addr_o (bank_addr),
        .coeff_i     (coeff),
        .ring_pop_o  (in_pop_o),
        .offset_o    (offset),
        .sample_i    (ring_data),
        .req_i       (out_pop_i),
        .data_o      (out_data_o),
        .ack_o       (out_ack_o)
    );

endmodule

/* upsample2x_checker.sv */
`timescale 1ns/1ns

module upsample2x_checker (
    input logic                                clk,
    input logic                                rst,
    input logic                                out_pop_i,
    input logic                                out_ack_i,
    input logic [upsample2x_pkg::SAMPLE_W-1:0] out_data_i,
    input logic                                in_pop_i,
    input upsample2x_pkg::fir_state_e          fir_state_i
);

    // cycles the engine stays busy after an ack
    localparam int BUSY_CYCLES = upsample2x_pkg::FIRDEPTH + 4;
    localparam int SINCE_MAX = 1000;

    int since_ack;
    int ack_total;
    int pop_total;

    int quiet_fails = 0;
    int req_fails = 0;
    int drop_fails = 0;
    int spacing_fails = 0;
    int cadence_fails = 0;
    int hold_fails = 0;
    int fail_count;

    assign fail_count = quiet_fails + req_fails + drop_fails + spacing_fails
                      + cadence_fails + hold_fails;

    // cycles since the last ack, and running ack and pop totals
    always_ff @(posedge clk) begin
        if (rst) begin
            since_ack <= SINCE_MAX;
            ack_total <= 0;
            pop_total <= 0;
        end else begin
            if (out_ack_i) begin
                since_ack <= 1;
                ack_total <= ack_total + 1;
            end else if (since_ack < SINCE_MAX) begin
                since_ack <= since_ack + 1;
            end
            if (in_pop_i) begin
                pop_total <= pop_total + 1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) rst |=> !out_ack_i && !in_pop_i)
        else begin
            quiet_fails = quiet_fails + 1;
            $error("out_ack_o or in_pop_o high during reset or right after it");
        end

    a_ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        out_pop_i && fir_state_i == upsample2x_pkg::ST_IDLE |=> out_ack_i)
        else begin
            req_fails = req_fails + 1;
            $error("request seen while idle was not acked in the next cycle");
        end

    // busy requests are dropped, not queued
    a_busy_drop: assert property (@(posedge clk) disable iff (rst)
        out_pop_i && fir_state_i != upsample2x_pkg::ST_IDLE |=> !out_ack_i)
        else begin
            drop_fails = drop_fails + 1;
            $error("request made while busy was acked");
        end

    a_ack_spacing: assert property (@(posedge clk) disable iff (rst)
        out_ack_i |-> since_ack > BUSY_CYCLES)
        else begin
            spacing_fails = spacing_fails + 1;
            $error("second ack inside the busy window of the previous one");
        end

    // one pop per pair of acks, inside the window after the second ack
    a_pop_cadence: assert property (@(posedge clk) disable iff (rst)
        in_pop_i |-> since_ack <= BUSY_CYCLES && ack_total == 2 * (pop_total + 1))
        else begin
            cadence_fails = cadence_fails + 1;
            $error("in_pop_o out of step with out_ack_o");
        end

    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        !out_ack_i |-> $stable(out_data_i))
        else begin
            hold_fails = hold_fails + 1;
            $error("out_data_o changed between acks");
        end

endmodule

/* tb_upsample2x.sv */
`timescale 1ns/1ns

module tb_upsample2x;

    localparam int RING_LEN = 64;
    localparam int PTR_W = $clog2(RING_LEN);
    localparam int SAMPLE_W = upsample2x_pkg::SAMPLE_W;
    localparam int COEFF_W = upsample2x_pkg::COEFF_W;
    localparam int TAP_W = upsample2x_pkg::TAP_W;
    localparam int PHASE_W = upsample2x_pkg::PHASE_W;
    localparam int PROD_W = SAMPLE_W + COEFF_W;
    localparam int BUSY_CYCLES = upsample2x_pkg::FIRDEPTH + 4;
    localparam int WAIT_LIMIT = 100;
    localparam int NUM_OUT = 96;
    localparam int CONST_FILL = 32;
    localparam logic [SAMPLE_W-1:0] CONST_SAMPLE = 24'h10_0000;
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(upsample2x_pkg::NUM_FIR - 1);

    logic                clk;
    logic                rst;
    logic [SAMPLE_W-1:0] in_data;
    logic                in_ack;
    logic                in_pop;
    logic                out_pop;
    logic [SAMPLE_W-1:0] out_data;
    logic                out_ack;

    // software copy of the ring and the expected next output
    logic [SAMPLE_W-1:0] sw_ring [RING_LEN];
    logic [PTR_W-1:0]    wr_idx;
    logic [PTR_W-1:0]    rd_mirror;
    logic [SAMPLE_W-1:0] exp_data;
    int                  out_count;
    int                  errors;
    int                  seed;
    logic                aborted;

    upsample2x #(
        .RING_LEN(RING_LEN)
    ) upsample2x_inst (
        .clk        (clk),
        .rst        (rst),
        .in_data_i  (in_data),
        .in_ack_i   (in_ack),
        .in_pop_o   (in_pop),
        .out_pop_i  (out_pop),
        .out_data_o (out_data),
        .out_ack_o  (out_ack)
    );

    bind upsample2x upsample2x_checker upsample2x_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .out_pop_i   (out_pop_i),
        .out_ack_i   (out_ack_o),
        .out_data_i  (out_data_o),
        .in_pop_i    (in_pop_o),
        .fir_state_i (poly_fir_inst.state_q)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sum of 32 products shifted right by 16 and wrapped at 24 bits
    function automatic logic [SAMPLE_W-1:0] poly_sum(input logic [PHASE_W-1:0] ph,
                                                     input logic [PTR_W-1:0] base);
        int                         k;
        logic [PTR_W-1:0]           idx;
        logic signed [SAMPLE_W-1:0] s;
        logic signed [COEFF_W-1:0]  c;
        logic signed [PROD_W-1:0]   prod;
        logic signed [PROD_W-1:0]   shifted;
        logic [SAMPLE_W-1:0]        acc;
        acc = '0;
        for (k = 0; k < upsample2x_pkg::FIRDEPTH; k++) begin
            idx = base + PTR_W'(k);
            s = sw_ring[idx];
            c = upsample2x_pkg::COEFF_TABLE[ph][TAP_W'(k)];
            prod = PROD_W'(s) * PROD_W'(c);
            shifted = prod >>> 16;
            acc = acc + shifted[SAMPLE_W-1:0];
        end
        return acc;
    endfunction

    task automatic write_sample(input logic [SAMPLE_W-1:0] value);
        @(posedge clk);
        in_data <= value;
        in_ack <= 1'b1;
        sw_ring[wr_idx] = value;
        wr_idx = wr_idx + 1'b1;
        @(posedge clk);
        in_ack <= 1'b0;
    endtask

    task automatic request_output();
        int n;
        n = 0;
        @(posedge clk);
        out_pop <= 1'b1;
        @(posedge clk);
        out_pop <= 1'b0;
        @(negedge clk);
        while (!out_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!out_ack) begin
            $display("timeout: no out_ack_o within %0d cycles of a request", WAIT_LIMIT);
            errors++;
            aborted = 1'b1;
        end else begin
            assert (out_data == exp_data) else begin
                errors++;
                $display("ERR %0t: output %0d is %h, expected %h",
                         $time, out_count, out_data, exp_data);
            end
        end
    endtask

    // a request inside the busy window that the engine should drop
    task automatic early_request(input int delay);
        repeat (delay) @(posedge clk);
        out_pop <= 1'b1;
        @(posedge clk);
        out_pop <= 1'b0;
    endtask

    task automatic wait_pop();
        int n;
        n = 0;
        @(negedge clk);
        while (!in_pop && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!in_pop) begin
            $display("timeout: no in_pop_o within %0d cycles after the second ack", WAIT_LIMIT);
            errors++;
            aborted = 1'b1;
        end else begin
            rd_mirror = rd_mirror + 1'b1;
        end
    endtask

    initial begin
        int                 i;
        int                 n;
        int                 r;
        int                 delay;
        int                 used;
        int                 assert_fails;
        logic [PHASE_W-1:0] phase;
        rst = 1'b1;
        in_data = '0;
        in_ack = 1'b0;
        out_pop = 1'b0;
        seed = 32'h3405_6cbb;
        wr_idx = '0;
        rd_mirror = '0;
        exp_data = '0;
        out_count = 0;
        errors = 0;
        aborted = 1'b0;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // constant block first, random samples after
        for (i = 0; i < RING_LEN; i++) begin
            if (i < CONST_FILL) begin
                write_sample(CONST_SAMPLE);
            end else begin
                write_sample(SAMPLE_W'($random(seed)));
            end
        end

        for (n = 0; n < NUM_OUT && !aborted; n++) begin
            request_output();
            if (!aborted) begin
                // the acked request starts the compute for this phase
                phase = PHASE_W'(out_count % upsample2x_pkg::NUM_FIR);
                exp_data = poly_sum(phase, rd_mirror);
                out_count++;
                r = $random(seed);
                delay = r & 7;
                used = 0;
                if (delay != 0) begin
                    early_request(delay);
                    used = delay + 1;
                end
                if (phase == PHASE_LAST) begin
                    wait_pop();
                    if (!aborted) begin
                        write_sample(SAMPLE_W'($random(seed)));
                    end
                end else begin
                    repeat (BUSY_CYCLES + 1 - used) @(posedge clk);
                end
            end
        end

        repeat (5) @(posedge clk);
        assert_fails = upsample2x_inst.upsample2x_checker_inst.fail_count;
        $display("errors: %0d value or timeout, %0d assertion, %0d outputs checked",
                 errors, assert_fails, out_count);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* upsample2x.f */
upsample2x_pkg.sv
coeff_rom.sv
sample_ring.sv
poly_fir.sv
upsample2x.sv
upsample2x_checker.sv
tb_upsample2x.sv

/* run_sim.sh */
#!/bin/sh
# build the upsample2x testbench with Verilator, run it, judge the log

LOG=sim.log

rm -rf obj_dir "$LOG" build.log

verilator --binary --timing --assert -f upsample2x.f --top-module tb_upsample2x \
    -o tb_upsample2x > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_upsample2x +verilator+error+limit+1000 > "$LOG" 2>&1
cat "$LOG"

grep -q "CHECKS FAILED" "$LOG" && { echo "simulation failed"; exit 1; } \
    || grep -q "ALL CHECKS PASSED" "$LOG" && { echo "simulation passed"; exit 0; } \
    || { echo "simulation ended without a verdict"; exit 1; }
